/* build.f */
+incdir+.
cpu_pkg.sv
register_file.sv
dispatch_unit.sv
alu_lane.sv
retire_unit.sv
cpu_core.sv
cpu_core_props.sv
tb_cpu_core.sv

/* tb_cpu_core.sv */
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_core;

    // about 300 transfers over all tests, rounded up.
    localparam int TRANSFERS  = 400;
    localparam int MAX_CYCLES = 20 * TRANSFERS + 200;
    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    logic                       clk;
    logic                       rstn;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`CPU_APB_ADDR_W-1:0] paddr;
    logic [`CPU_XLEN-1:0]       pwdata;
    logic [`CPU_XLEN-1:0]       prdata;
    logic                       pready;
    logic                       pslverr;

    logic [`CPU_XLEN-1:0] model [`CPU_REG_COUNT];
    logic [31:0]          rng;
    int                   errors;
    int                   checks;
    int                   cycles;
    int                   waits;
    int                   accepted;

    cpu_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // rv32i alu semantics, alt selects sub and sra.
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    // pready is sampled on the falling edge, the transfer ends on the next rise.
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic commit(input logic [4:0] rd, input logic [31:0] value, input logic err);
        check_true(!err, "supported instruction returned pslverr");
        if (!err) begin
            accepted++;
            if (rd != 5'd0) begin
                model[rd] = value;
            end
        end
    endtask

    task automatic op_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        logic        err;
        logic [31:0] value;
        value = alu_ref(f3, alt, model[rs1], model[rs2]);
        apb_write(`CPU_ADDR_INSTR, enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd), err);
        commit(rd, value, err);
    endtask

    task automatic op_i(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                        input logic [4:0] rs1);
        logic        err;
        logic [31:0] value;
        value = alu_ref(f3, f3 == 3'd5 && imm[10], model[rs1], {{20{imm[11]}}, imm});
        apb_write(`CPU_ADDR_INSTR, enc_i(imm, rs1, f3, rd), err);
        commit(rd, value, err);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        logic        err;
        status = 32'hffff_ffff;
        while (status != 32'd0) begin
            apb_read(`CPU_ADDR_STATUS, status, err);
        end
    endtask

    task automatic check_regs(input string test);
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            apb_read(12'(`CPU_ADDR_REG_BASE + 4 * i), data, err);
            check_value(data, model[i], $sformatf("%s x%0d", test, i));
            check_true(!err, $sformatf("read of x%0d returned pslverr", i));
        end
    endtask

    task automatic test_reset();
        logic [31:0] status;
        logic        err;
        apb_read(`CPU_ADDR_STATUS, status, err);
        check_value(status, 32'd0, "status after reset");
        check_true(!err, "status read after reset returned pslverr");
        check_regs("reset");
    endtask

    task automatic test_out_of_order();
        logic [31:0] status;
        logic        err;
        op_i(3'd0, 12'd100, 5'd1, 5'd0);
        op_i(3'd0, 12'h7ff, 5'd2, 5'd0);
        op_i(3'd0, 12'hed4, 5'd3, 5'd0);
        op_i(3'd4, 12'h555, 5'd4, 5'd0);
        op_i(3'd0, 12'd7, 5'd5, 5'd0);
        wait_idle();
        // nop so the burst starts in the slow lane.
        if (accepted % 2 == 0) begin
            op_i(3'd0, 12'd0, 5'd0, 5'd0);
        end
        op_r(3'd0, 1'b1, 5'd10, 5'd1, 5'd2);
        op_r(3'd4, 1'b0, 5'd11, 5'd3, 5'd4);
        op_r(3'd1, 1'b0, 5'd12, 5'd3, 5'd5);
        op_r(3'd3, 1'b0, 5'd13, 5'd3, 5'd1);
        apb_read(`CPU_ADDR_STATUS, status, err);
        check_true(status > 32'd1, "in-flight count did not rise above 1");
        wait_idle();
        check_regs("out-of-order");
    endtask

    task automatic test_dependent_chain();
        op_r(3'd0, 1'b0, 5'd20, 5'd1, 5'd2);
        op_r(3'd0, 1'b0, 5'd21, 5'd20, 5'd1);
        check_true(waits > 0, "dependent instruction did not wait on pready");
        op_r(3'd4, 1'b0, 5'd22, 5'd21, 5'd20);
        op_r(3'd0, 1'b1, 5'd20, 5'd22, 5'd3);
        op_r(3'd7, 1'b0, 5'd23, 5'd20, 5'd21);
        wait_idle();
        check_regs("chain");
    endtask

    task automatic test_immediates();
        op_i(3'd0, 12'hffb, 5'd6, 5'd0);
        op_i(3'd5, 12'h401, 5'd7, 5'd6);
        op_i(3'd5, 12'h001, 5'd8, 5'd6);
        op_i(3'd2, 12'h001, 5'd9, 5'd6);
        op_i(3'd3, 12'h001, 5'd14, 5'd6);
        op_i(3'd6, 12'hf00, 5'd15, 5'd4);
        op_i(3'd7, 12'hff0, 5'd16, 5'd2);
        op_i(3'd1, 12'h004, 5'd17, 5'd6);
        op_i(3'd0, 12'd7, 5'd0, 5'd6);
        wait_idle();
        check_regs("immediates");
    endtask

    task automatic test_errors();
        logic [31:0] data;
        logic        err;
        // a load, then a multiply.
        apb_write(`CPU_ADDR_INSTR, {12'h0, 5'd1, 3'b010, 5'd5, 7'b0000011}, err);
        check_true(err, "unsupported opcode completed without pslverr");
        apb_write(`CPU_ADDR_INSTR, enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5), err);
        check_true(err, "unsupported funct7 completed without pslverr");
        apb_write(`CPU_ADDR_STATUS, 32'd3, err);
        check_true(err, "write to the status address completed without pslverr");
        apb_read(12'h100, data, err);
        check_true(err, "read above the register window completed without pslverr");
        apb_read(`CPU_ADDR_STATUS, data, err);
        check_value(data, 32'd0, "status after error accesses");
        check_regs("errors");
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        for (int n = 0; n < 40; n++) begin
            r  = next_rand();
            f3 = r[2:0];
            if (r[19]) begin
                op_r(f3, r[18] && (f3 == 3'd0 || f3 == 3'd5), r[7:3], r[12:8], r[17:13]);
            end else begin
                imm = r[31:20];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, r[18] && f3 == 3'd5, 5'b0, r[24:20]};
                end
                op_i(f3, imm, r[7:3], r[12:8]);
            end
        end
        wait_idle();
        check_regs("random");
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        accepted = 0;
        rng      = 32'd33;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            model[i] = '0;
        end
        rstn    <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_out_of_order();
        test_dependent_chain();
        test_immediates();
        test_errors();
        test_random();
        errors += DUT.u_props.failures;
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_core_props.sv */
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_props (
    input wire                                   clk,
    input wire                                   rstn,
    input wire                                   psel,
    input wire                                   penable,
    input wire                                   pready,
    input wire                                   pslverr,
    input wire cpu_pkg::issue_t                  issue0,
    input wire cpu_pkg::issue_t                  issue1,
    input wire cpu_pkg::result_t                 retired,
    input wire [`CPU_REG_COUNT-1:0]              busy,
    input wire [$clog2(`CPU_ROB_DEPTH + 1)-1:0]  in_flight
);

    // read by the testbench at the end of the run.
    int failures = 0;

    a_err_in_access: assert property (@(posedge clk) disable iff (!rstn)
        pslverr |-> psel && penable && pready)
    else begin
        failures++;
        $error("pslverr high outside a completing access");
    end

    a_one_issue: assert property (@(posedge clk) disable iff (!rstn)
        !(issue0.valid && issue1.valid))
    else begin
        failures++;
        $error("both lanes issued in the same cycle");
    end

    // the scoreboard holds the dest busy until its own retirement.
    a_dest_busy: assert property (@(posedge clk) disable iff (!rstn)
        retired.valid && retired.dest != '0 |-> busy[retired.dest])
    else begin
        failures++;
        $error("retired dest was already free in the scoreboard");
    end

    a_count_limit: assert property (@(posedge clk) disable iff (!rstn)
        in_flight <= `CPU_ROB_DEPTH)
    else begin
        failures++;
        $error("in-flight count above the reorder depth");
    end

endmodule

bind cpu_core cpu_core_props u_props (
    .*,
    .busy      (u_dispatch.busy),
    .in_flight (u_dispatch.in_flight)
);

`default_nettype wire

/* cpu_core.sv */
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire [`CPU_APB_ADDR_W-1:0]   paddr,
    input  wire [`CPU_XLEN-1:0]         pwdata,
    output logic [`CPU_XLEN-1:0]        prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import cpu_pkg::*;

    logic [`CPU_REG_IDX_W-1:0] rd_idx_a;
    logic [`CPU_REG_IDX_W-1:0] rd_idx_b;
    logic [`CPU_REG_IDX_W-1:0] rd_idx_host;
    logic [`CPU_XLEN-1:0]      rd_data_a;
    logic [`CPU_XLEN-1:0]      rd_data_b;
    logic [`CPU_XLEN-1:0]      rd_data_host;
    issue_t                    issue0;
    issue_t                    issue1;
    result_t                   result0;
    result_t                   result1;
    result_t                   retired;

    dispatch_unit u_dispatch (.*);

    // retire is the only writer of the register file.
    register_file u_regs (
        .*,
        .wr (retired)
    );

    // short and long lane, so results come back out of order.
    alu_lane #(.LATENCY(1)) lane0 (
        .clk,
        .rstn,
        .issue  (issue0),
        .result (result0)
    );

    alu_lane #(.LATENCY(3)) lane1 (
        .clk,
        .rstn,
        .issue  (issue1),
        .result (result1)
    );

    retire_unit u_retire (.*);

endmodule

`default_nettype wire

/* retire_unit.sv */
`default_nettype none

`include "cpu_defines.svh"

module retire_unit (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire cpu_pkg::result_t   result0,
    input  wire cpu_pkg::result_t   result1,
    output cpu_pkg::result_t        retired
);
    import cpu_pkg::*;

    logic [`CPU_ROB_DEPTH-1:0] slot_valid;
    logic [`CPU_REG_IDX_W-1:0] slot_dest  [`CPU_ROB_DEPTH];
    logic [`CPU_XLEN-1:0]      slot_value [`CPU_ROB_DEPTH];
    logic [`CPU_TAG_W-1:0]     head;
    logic                      head_ready;
    logic                      retired_v;
    result_t                   retired_q;

    // oldest tag, in program order.
    assign head_ready = slot_valid[head];

    // tags in flight are unique, so the lanes never hit the same slot.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_valid <= '0;
            head       <= '0;
            retired_v  <= 1'b0;
        end else begin
            if (head_ready) begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            if (result0.valid) begin
                slot_valid[result0.tag] <= 1'b1;
            end
            if (result1.valid) begin
                slot_valid[result1.tag] <= 1'b1;
            end
            retired_v <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (result0.valid) begin
            slot_dest[result0.tag]  <= result0.dest;
            slot_value[result0.tag] <= result0.value;
        end
        if (result1.valid) begin
            slot_dest[result1.tag]  <= result1.dest;
            slot_value[result1.tag] <= result1.value;
        end
        if (head_ready) begin
            retired_q.valid <= 1'b1;
            retired_q.tag   <= head;
            retired_q.dest  <= slot_dest[head];
            retired_q.value <= slot_value[head];
        end
    end

    always_comb begin
        retired       = retired_q;
        retired.valid = retired_v;
    end

endmodule

`default_nettype wire

/* alu_lane.sv */
`default_nettype none

`include "cpu_defines.svh"

module alu_lane #(
    parameter int LATENCY = 1
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire cpu_pkg::issue_t   issue,
    output cpu_pkg::result_t       result
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] alu_out;
    logic [4:0]           shamt;
    logic [LATENCY-1:0]   stage_v;
    result_t              stage_q [LATENCY];

    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            ADD:     alu_out = issue.a + issue.b;
            SUB:     alu_out = issue.a - issue.b;
            SLL:     alu_out = issue.a << shamt;
            SLT:     alu_out = {{(`CPU_XLEN - 1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            SLTU:    alu_out = {{(`CPU_XLEN - 1){1'b0}}, issue.a < issue.b};
            XOR:     alu_out = issue.a ^ issue.b;
            SRL:     alu_out = issue.a >> shamt;
            SRA:     alu_out = $signed(issue.a) >>> shamt;
            OR:      alu_out = issue.a | issue.b;
            AND:     alu_out = issue.a & issue.b;
            default: alu_out = '0;
        endcase
    end

    // valid chain, one stage per cycle of latency.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_v <= '0;
        end else begin
            stage_v[0] <= issue.valid;
            for (int i = 1; i < LATENCY; i++) begin
                stage_v[i] <= stage_v[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage_q[0] <= '{valid: 1'b1, tag: issue.tag, dest: issue.dest, value: alu_out};
        for (int i = 1; i < LATENCY; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    always_comb begin
        result       = stage_q[LATENCY-1];
        result.valid = stage_v[LATENCY-1];
    end

endmodule

`default_nettype wire

/* dispatch_unit.sv */
`default_nettype none

`include "cpu_defines.svh"

module dispatch_unit (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [`CPU_APB_ADDR_W-1:0]    paddr,
    input  wire [`CPU_XLEN-1:0]          pwdata,
    output logic [`CPU_XLEN-1:0]         prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic [`CPU_REG_IDX_W-1:0]    rd_idx_a,
    output logic [`CPU_REG_IDX_W-1:0]    rd_idx_b,
    output logic [`CPU_REG_IDX_W-1:0]    rd_idx_host,
    input  wire [`CPU_XLEN-1:0]          rd_data_a,
    input  wire [`CPU_XLEN-1:0]          rd_data_b,
    input  wire [`CPU_XLEN-1:0]          rd_data_host,
    output cpu_pkg::issue_t              issue0,
    output cpu_pkg::issue_t              issue1,
    input  wire cpu_pkg::result_t        retired
);
    import cpu_pkg::*;

    localparam int CNT_W = $clog2(`CPU_ROB_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`CPU_ROB_DEPTH);
    localparam int REG_WIN_END = `CPU_ADDR_REG_BASE + 4 * `CPU_REG_COUNT;

    logic                        access;
    logic                        instr_wr;
    logic                        status_rd;
    logic                        reg_rd;
    logic [6:0]                  opcode;
    logic [6:0]                  funct7;
    logic [6:0]                  f7_eff;
    logic [2:0]                  funct3;
    logic [`CPU_REG_IDX_W-1:0]   rs1;
    logic [`CPU_REG_IDX_W-1:0]   rs2;
    logic [`CPU_REG_IDX_W-1:0]   rd;
    logic [`CPU_XLEN-1:0]        imm;
    logic                        is_op;
    logic                        is_imm;
    logic                        known;
    logic                        legal;
    logic                        hazard;
    logic                        accept;
    alu_op_e                     op;
    logic [`CPU_REG_COUNT-1:0]   busy;
    logic [CNT_W-1:0]            in_flight;
    logic [`CPU_TAG_W-1:0]       next_tag;
    logic                        lane_sel;
    logic                        issue0_v;
    logic                        issue1_v;
    issue_t                      issue_q;

    assign access    = psel & penable;
    assign instr_wr  = access & pwrite & (paddr == `CPU_ADDR_INSTR);
    assign status_rd = paddr == `CPU_ADDR_STATUS;
    assign reg_rd    = paddr >= `CPU_ADDR_REG_BASE && paddr < REG_WIN_END && paddr[1:0] == 2'b00;

    // instruction fields.
    assign opcode = pwdata[6:0];
    assign rd     = pwdata[11:7];
    assign funct3 = pwdata[14:12];
    assign rs1    = pwdata[19:15];
    assign rs2    = pwdata[24:20];
    assign funct7 = pwdata[31:25];
    assign imm    = {{(`CPU_XLEN - 12){pwdata[31]}}, pwdata[31:20]};
    assign is_op  = opcode == 7'b0110011;
    assign is_imm = opcode == 7'b0010011;

    // for op-imm only the shifts carry a funct7.
    assign f7_eff = (is_op || funct3[1:0] == 2'b01) ? funct7 : 7'h00;

    always_comb begin
        op    = ADD;
        known = 1'b1;
        case ({f7_eff, funct3})
            {7'h00, 3'b000}: op = ADD;
            {7'h20, 3'b000}: op = SUB;
            {7'h00, 3'b001}: op = SLL;
            {7'h00, 3'b010}: op = SLT;
            {7'h00, 3'b011}: op = SLTU;
            {7'h00, 3'b100}: op = XOR;
            {7'h00, 3'b101}: op = SRL;
            {7'h20, 3'b101}: op = SRA;
            {7'h00, 3'b110}: op = OR;
            {7'h00, 3'b111}: op = AND;
            default:         known = 1'b0;
        endcase
    end

    assign legal  = (is_op | is_imm) & known;
    // rs2 is a source only for r-type.
    assign hazard = busy[rs1] | (is_op & busy[rs2]) | busy[rd] | (in_flight == FULL);
    assign accept = instr_wr & legal & ~hazard;

    always_comb begin
        pslverr = 1'b0;
        pready  = 1'b0;
        if (access) begin
            if (pwrite) begin
                pslverr = paddr != `CPU_ADDR_INSTR || !legal;
                pready  = pslverr | ~hazard;
            end else begin
                pslverr = ~(status_rd | reg_rd);
                pready  = 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (status_rd) begin
            prdata[CNT_W-1:0] = in_flight;
        end else if (reg_rd) begin
            prdata = rd_data_host;
        end
    end

    assign rd_idx_a    = rs1;
    assign rd_idx_b    = rs2;
    assign rd_idx_host = paddr[2 +: `CPU_REG_IDX_W];

    // scoreboard, count, tags and lane toggle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy      <= '0;
            in_flight <= '0;
            next_tag  <= '0;
            lane_sel  <= 1'b0;
            issue0_v  <= 1'b0;
            issue1_v  <= 1'b0;
        end else begin
            if (retired.valid) begin
                busy[retired.dest] <= 1'b0;
            end
            if (accept && rd != '0) begin
                busy[rd] <= 1'b1;
            end
            case ({accept, retired.valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
            issue0_v <= accept & ~lane_sel;
            issue1_v <= accept & lane_sel;
            if (accept) begin
                next_tag <= next_tag + 1'b1;
                lane_sel <= ~lane_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q.valid <= 1'b1;
            issue_q.tag   <= next_tag;
            issue_q.op    <= op;
            issue_q.a     <= rd_data_a;
            issue_q.b     <= is_imm ? imm : rd_data_b;
            issue_q.dest  <= rd;
        end
    end

    // one payload, valid only toward the chosen lane.
    always_comb begin
        issue0       = issue_q;
        issue0.valid = issue0_v;
        issue1       = issue_q;
        issue1.valid = issue1_v;
    end

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none

`include "cpu_defines.svh"

module register_file (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire [`CPU_REG_IDX_W-1:0]   rd_idx_a,
    input  wire [`CPU_REG_IDX_W-1:0]   rd_idx_b,
    input  wire [`CPU_REG_IDX_W-1:0]   rd_idx_host,
    output logic [`CPU_XLEN-1:0]       rd_data_a,
    output logic [`CPU_XLEN-1:0]       rd_data_b,
    output logic [`CPU_XLEN-1:0]       rd_data_host,
    input  wire cpu_pkg::result_t      wr
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    // x0 is cleared by reset and never written after.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.dest != '0) begin
            regs[wr.dest] <= wr.value;
        end
    end

    // two operand ports and the host port.
    assign rd_data_a    = regs[rd_idx_a];
    assign rd_data_b    = regs[rd_idx_b];
    assign rd_data_host = regs[rd_idx_host];

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // operations both lanes can execute.
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // instruction on its way from dispatch to a lane.
    typedef struct packed {
        logic                      valid;
        logic [`CPU_TAG_W-1:0]     tag;
        alu_op_e                   op;
        logic [`CPU_XLEN-1:0]      a;
        logic [`CPU_XLEN-1:0]      b;    // rs2 data or sign-extended immediate.
        logic [`CPU_REG_IDX_W-1:0] dest;
    } issue_t;

    // lane output, also the retire write.
    typedef struct packed {
        logic                      valid;
        logic [`CPU_TAG_W-1:0]     tag;
        logic [`CPU_REG_IDX_W-1:0] dest;
        logic [`CPU_XLEN-1:0]      value;
    } result_t;

endpackage

`default_nettype wire

/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and architectural registers.
`define CPU_XLEN          32
`define CPU_REG_COUNT     32
`define CPU_REG_IDX_W     5

// reorder tags, one per in-flight instruction.
`define CPU_TAG_W         2
`define CPU_ROB_DEPTH     4

// apb address map.
`define CPU_APB_ADDR_W    12
`define CPU_ADDR_INSTR    12'h000
`define CPU_ADDR_STATUS   12'h004

// register window, register n at base + 4n.
`define CPU_ADDR_REG_BASE 12'h080

`endif
